// File: Makefile
SIM       = verilator
SIM_FLAGS = --binary --timing --assert -j 0
TOP       = dcache_tb
FILELIST  = dcache.f
OBJ_DIR   = obj_dir
RUN_ARGS  = +verilator+error+limit+100
LOG       = sim.log

SOURCES = $(shell grep -v '^+' $(FILELIST))
BIN     = $(OBJ_DIR)/V$(TOP)

.PHONY: all build run clean

all: run

build: $(BIN)

$(BIN): $(SOURCES) $(FILELIST)
	$(SIM) $(SIM_FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: $(BIN)
	./$(BIN) $(RUN_ARGS) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@grep -qx 'Test OK' $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: dcache.f
hw/dcache_pkg.sv
hw/dcache_data_array.sv
hw/dcache_tag_array.sv
hw/dcache_lookup.sv
hw/dcache_ctrl.sv
hw/dcache_top.sv
verif/dcache_props.sv
verif/tb_clock.sv
verif/dcache_tb.sv

// File: hw/dcache_ctrl.sv
`timescale 1ns/1ns
`default_nettype none

module dcache_ctrl
    import dcache_pkg::*;
#(
    parameter  int SET_BITS = 9,
    localparam int TAG_W    = tag_bits_f(SET_BITS),
    localparam int ENTRY_W  = entry_bits_f(SET_BITS)
) (
    input  logic                       clock,
    input  logic                       reset_n,
    input  logic                       req_valid,
    input  logic [1:0]                 req_op,
    input  logic [ADDR_BITS-1:0]       req_addr,
    input  logic [WORD_BITS-1:0]       req_wdata,
    input  logic [WORD_BITS-1:0]       req_wmask,
    output logic                       req_ready,
    output logic                       resp_done,
    output logic [WORD_BITS-1:0]       resp_rdata,
    output logic                       mem_valid,
    output logic [1:0]                 mem_op,
    output logic [ADDR_BITS-1:0]       mem_addr,
    output logic [LINE_BITS-1:0]       mem_wline,
    input  logic                       mem_ready,
    input  logic                       mem_done,
    input  logic [LINE_BITS-1:0]       mem_rline,
    output logic                       tag_rd_en,
    output logic                       tag_wr_en,
    output logic [SET_BITS-1:0]        tag_set,
    output logic [WAY_NUM*ENTRY_W-1:0] tag_wr_entry,
    input  logic [WAY_NUM*ENTRY_W-1:0] tag_rdata,
    output logic                       data_wr_en,
    output logic [WAY_NUM-1:0]         data_way_en,
    output logic [BANK_NUM-1:0]        data_bank_en,
    output logic [SET_BITS-1:0]        data_set,
    output line_u                      data_wr_line,
    output line_u                      data_wr_mask,
    input  line_u                      data_rdata,
    output logic                       lookup_step,
    output logic [TAG_W-1:0]           req_tag,
    input  logic                       hit,
    input  logic [WAY_SEL_BITS-1:0]    hit_way,
    input  logic [WAY_SEL_BITS-1:0]    victim_way,
    input  logic                       victim_dirty,
    input  logic [TAG_W-1:0]           victim_tag
);

    localparam logic [2:0] st_idle        = 3'd0;
    localparam logic [2:0] st_lookup      = 3'd1;
    localparam logic [2:0] st_write_cache = 3'd2;
    localparam logic [2:0] st_read_cache  = 3'd3;
    localparam logic [2:0] st_write_mem   = 3'd4;
    localparam logic [2:0] st_read_mem    = 3'd5;
    localparam logic [2:0] st_refill      = 3'd6;

    logic [2:0]               state;
    logic [2:0]               state_nx;
    logic                     rd_phase;   // line out of the data array
    logic                     accept;
    logic                     wb_start;
    logic                     rd_start;
    logic [ADDR_BITS-1:0]     addr_q;
    logic [1:0]               op_q;
    logic [WORD_BITS-1:0]     wdata_q;
    logic [WORD_BITS-1:0]     wmask_q;
    logic [SET_BITS-1:0]      set_q;
    logic [BANK_SEL_BITS-1:0] bank_sel;
    logic [WAY_SEL_BITS-1:0]  rd_way;
    line_u                    fill_q;     // line returned by memory
    line_u                    fill_line;

    assign req_ready   = (state == st_idle);
    assign accept      = req_valid & req_ready;
    assign lookup_step = accept;
    assign set_q       = addr_q[OFFSET_BITS +: SET_BITS];
    assign bank_sel    = addr_q[OFFSET_BITS-1 -: BANK_SEL_BITS];
    assign req_tag     = addr_q[ADDR_BITS-1 -: TAG_W];

    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            state    <= st_idle;
            rd_phase <= 1'b0;
            op_q     <= op_read;
        end else begin
            state    <= state_nx;
            rd_phase <= (state == st_read_cache) && !rd_phase;
            if (accept) begin
                op_q <= req_op;
            end
        end
    end

    always_ff @(posedge clock) begin
        if (accept) begin
            addr_q  <= req_addr;
            wdata_q <= req_wdata;
            wmask_q <= req_wmask;
        end
        if (state == st_read_mem && mem_done) begin
            fill_q.flat <= mem_rline;
        end
    end

    always_comb begin
        state_nx = state;
        case (state)
            st_idle:        if (accept) state_nx = st_lookup;
            st_lookup: begin
                if (hit) begin
                    state_nx = (op_q == op_write) ? st_write_cache : st_read_cache;
                end else begin
                    state_nx = victim_dirty ? st_read_cache : st_read_mem;
                end
            end
            st_write_cache: state_nx = st_idle;
            st_read_cache:  if (rd_phase) state_nx = hit ? st_idle : st_write_mem;
            st_write_mem:   if (mem_done) state_nx = st_read_mem;
            st_read_mem:    if (mem_done) state_nx = st_refill;
            st_refill:      state_nx = st_idle;
            default:        state_nx = st_idle;
        endcase
    end

    // victim line sits on data_rdata in the second read_cache cycle
    assign wb_start = (state == st_read_cache) && rd_phase && !hit;
    assign rd_start = (state == st_lookup && !hit && !victim_dirty)
                   || (state == st_write_mem && mem_done);

    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            mem_valid <= 1'b0;
        end else if (mem_valid && mem_ready) begin
            mem_valid <= 1'b0;
        end else if (wb_start || rd_start) begin
            mem_valid <= 1'b1;
        end
    end

    always_ff @(posedge clock) begin
        if (wb_start) begin
            mem_op    <= op_write;
            mem_addr  <= {victim_tag, set_q, {OFFSET_BITS{1'b0}}};
            mem_wline <= data_rdata.flat;
        end else if (rd_start) begin
            mem_op    <= op_read;
            mem_addr  <= {req_tag, set_q, {OFFSET_BITS{1'b0}}};
        end
    end

    // store merge into the refilled bank
    always_comb begin
        fill_line = fill_q;
        if (op_q == op_write) begin
            fill_line.bank[bank_sel] = (wdata_q & wmask_q) | (fill_q.bank[bank_sel] & ~wmask_q);
        end
    end

    assign resp_done = (state == st_write_cache) || (state == st_refill)
                    || (state == st_read_cache && rd_phase && hit);

    always_comb begin
        resp_rdata = '0;
        if (state == st_read_cache && rd_phase && hit) begin
            resp_rdata = data_rdata.bank[bank_sel];
        end else if (state == st_refill && op_q == op_read) begin
            resp_rdata = fill_q.bank[bank_sel];
        end
    end

    assign tag_rd_en = accept;
    assign tag_wr_en = (state == st_write_cache) || (state == st_refill);
    assign tag_set   = (state == st_idle) ? req_addr[OFFSET_BITS +: SET_BITS] : set_q;
    assign data_set  = set_q;
    assign rd_way    = hit ? hit_way : victim_way;

    always_comb begin
        tag_wr_entry      = tag_rdata;   // other way written back unchanged
        data_wr_en        = 1'b0;
        data_way_en       = '0;
        data_bank_en      = '0;
        data_wr_line.flat = '0;
        data_wr_mask.flat = '0;
        case (state)
            st_write_cache: begin
                tag_wr_entry[hit_way*ENTRY_W + TAG_W] = 1'b1;   // dirty
                data_wr_en                  = 1'b1;
                data_way_en[hit_way]        = 1'b1;
                data_bank_en[bank_sel]      = 1'b1;
                data_wr_line.bank[bank_sel] = wdata_q;
                data_wr_mask.bank[bank_sel] = wmask_q;
            end
            st_read_cache: begin
                if (!rd_phase) begin
                    data_way_en[rd_way] = 1'b1;
                end
            end
            st_refill: begin
                tag_wr_entry[victim_way*ENTRY_W +: ENTRY_W] = {1'b1, op_q == op_write, req_tag};
                data_wr_en              = 1'b1;
                data_way_en[victim_way] = 1'b1;
                data_bank_en            = '1;
                data_wr_line            = fill_line;
                data_wr_mask.flat       = '1;   // whole line
            end
            default: ;
        endcase
    end

endmodule

`default_nettype wire

// File: hw/dcache_data_array.sv
`timescale 1ns/1ns
`default_nettype none

module dcache_data_array
    import dcache_pkg::*;
#(
    parameter int SET_BITS = 9
) (
    input  logic                clock,
    input  logic                wr_en,
    input  logic [WAY_NUM-1:0]  way_en,
    input  logic [BANK_NUM-1:0] bank_en,
    input  logic [SET_BITS-1:0] set_addr,
    input  line_u               wr_line,
    input  line_u               wr_mask,
    output line_u               rd_line
);

    localparam int SETS = 2 ** SET_BITS;

    // one 64-bit bank per way and word slot
    logic [WORD_BITS-1:0] bank_mem [WAY_NUM][BANK_NUM][SETS];

    // bit-masked write, only enabled banks of enabled ways
    always_ff @(posedge clock) begin
        if (wr_en) begin
            for (int w = 0; w < WAY_NUM; w++) begin
                for (int b = 0; b < BANK_NUM; b++) begin
                    if (way_en[w] && bank_en[b]) begin
                        bank_mem[w][b][set_addr] <=
                            (bank_mem[w][b][set_addr] & ~wr_mask.bank[b])
                            | (wr_line.bank[b] & wr_mask.bank[b]);
                    end
                end
            end
        end
    end

    // whole line of the enabled way, holds when no way is enabled
    always_ff @(posedge clock) begin
        if (!wr_en) begin
            for (int w = 0; w < WAY_NUM; w++) begin
                if (way_en[w]) begin
                    for (int b = 0; b < BANK_NUM; b++) begin
                        rd_line.bank[b] <= bank_mem[w][b][set_addr];
                    end
                end
            end
        end
    end

endmodule

`default_nettype wire

// File: hw/dcache_lookup.sv
`timescale 1ns/1ns
`default_nettype none

module dcache_lookup
    import dcache_pkg::*;
#(
    parameter  int SET_BITS = 9,
    localparam int TAG_W    = tag_bits_f(SET_BITS),
    localparam int ENTRY_W  = entry_bits_f(SET_BITS)
) (
    input  logic                       clock,
    input  logic                       reset_n,
    input  logic                       lookup_step,
    input  logic [TAG_W-1:0]           req_tag,
    input  logic [WAY_NUM*ENTRY_W-1:0] tag_rdata,
    output logic                       hit,
    output logic [WAY_SEL_BITS-1:0]    hit_way,
    output logic [WAY_SEL_BITS-1:0]    victim_way,
    output logic                       victim_dirty,
    output logic [TAG_W-1:0]           victim_tag
);

    logic [7:0]         lfsr_q;
    logic [WAY_NUM-1:0] way_valid;
    logic [WAY_NUM-1:0] way_dirty;
    logic [TAG_W-1:0]   way_tag [WAY_NUM];

    always_comb begin
        for (int w = 0; w < WAY_NUM; w++) begin
            way_tag[w]   = tag_rdata[w*ENTRY_W +: TAG_W];
            way_dirty[w] = tag_rdata[w*ENTRY_W + TAG_W];
            way_valid[w] = tag_rdata[w*ENTRY_W + TAG_W + 1];
        end
    end

    always_comb begin
        hit     = 1'b0;
        hit_way = '0;
        for (int w = WAY_NUM - 1; w >= 0; w--) begin
            if (way_valid[w] && way_tag[w] == req_tag) begin
                hit     = 1'b1;
                hit_way = WAY_SEL_BITS'(w);
            end
        end
    end

    // lowest empty way wins, random way when the set is full
    always_comb begin
        victim_way = lfsr_q[WAY_SEL_BITS-1:0];
        for (int w = WAY_NUM - 1; w >= 0; w--) begin
            if (!way_valid[w]) begin
                victim_way = WAY_SEL_BITS'(w);
            end
        end
    end

    assign victim_dirty = way_valid[victim_way] & way_dirty[victim_way];
    assign victim_tag   = way_tag[victim_way];

    // x^8 + x^6 + x^5 + x^4 + 1, one step per request
    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            lfsr_q <= 8'hff;
        end else if (lookup_step) begin
            lfsr_q <= {lfsr_q[6:0], lfsr_q[7] ^ lfsr_q[5] ^ lfsr_q[4] ^ lfsr_q[3]};
        end
    end

endmodule

`default_nettype wire

// File: hw/dcache_pkg.sv
`default_nettype none

package dcache_pkg;

    localparam int WORD_BITS   = 64;   // one core word
    localparam int BANK_NUM    = 8;    // words per line
    localparam int OFFSET_BITS = 6;    // byte offset in a line
    localparam int ADDR_BITS   = 32;
    localparam int WAY_NUM     = 2;
    localparam int LINE_BITS   = 512;

    localparam int BANK_SEL_BITS = $clog2(BANK_NUM);   // addr bits 5:3
    localparam int WAY_SEL_BITS  = $clog2(WAY_NUM);

    // request and memory operation codes
    localparam logic [1:0] op_read  = 2'b01;
    localparam logic [1:0] op_write = 2'b10;

    // whatever is left above set index and offset
    function automatic int tag_bits_f(input int set_bits);
        return ADDR_BITS - set_bits - OFFSET_BITS;
    endfunction

    // each way keeps {valid, dirty, tag}
    // way 0 sits in the low bits of a set entry
    function automatic int entry_bits_f(input int set_bits);
        return tag_bits_f(set_bits) + 2;
    endfunction

    // one cache line, seen flat by the memory port or as banks by the arrays
    typedef union packed {
        logic [LINE_BITS-1:0]               flat;
        logic [BANK_NUM-1:0][WORD_BITS-1:0] bank;
    } line_u;

endpackage

`default_nettype wire

// File: hw/dcache_tag_array.sv
`timescale 1ns/1ns
`default_nettype none

module dcache_tag_array
    import dcache_pkg::*;
#(
    parameter  int SET_BITS = 9,
    localparam int TAG_W    = tag_bits_f(SET_BITS),
    localparam int ENTRY_W  = entry_bits_f(SET_BITS)
) (
    input  logic                       clock,
    input  logic                       reset_n,
    input  logic                       rd_en,
    input  logic                       wr_en,
    input  logic [SET_BITS-1:0]        set_addr,
    input  logic [WAY_NUM*ENTRY_W-1:0] wr_entry,
    output logic [WAY_NUM*ENTRY_W-1:0] rd_entry
);

    localparam int SETS = 2 ** SET_BITS;

    logic [WAY_NUM-1:0]       valid_q [SETS];
    logic [WAY_NUM-1:0]       dirty_q [SETS];
    logic [WAY_NUM*TAG_W-1:0] tag_mem [SETS];

    // every line comes out of reset invalid and clean
    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            for (int s = 0; s < SETS; s++) begin
                valid_q[s] <= '0;
                dirty_q[s] <= '0;
            end
        end else if (wr_en) begin
            for (int w = 0; w < WAY_NUM; w++) begin
                valid_q[set_addr][w] <= wr_entry[w*ENTRY_W + TAG_W + 1];
                dirty_q[set_addr][w] <= wr_entry[w*ENTRY_W + TAG_W];
            end
        end
    end

    always_ff @(posedge clock) begin
        if (wr_en) begin
            for (int w = 0; w < WAY_NUM; w++) begin
                tag_mem[set_addr][w*TAG_W +: TAG_W] <= wr_entry[w*ENTRY_W +: TAG_W];
            end
        end
        if (rd_en) begin
            for (int w = 0; w < WAY_NUM; w++) begin
                rd_entry[w*ENTRY_W +: ENTRY_W] <= {valid_q[set_addr][w],
                                                   dirty_q[set_addr][w],
                                                   tag_mem[set_addr][w*TAG_W +: TAG_W]};
            end
        end
    end

endmodule

`default_nettype wire

// File: hw/dcache_top.sv
`timescale 1ns/1ns
`default_nettype none

module dcache_top
    import dcache_pkg::*;
#(
    parameter int SET_BITS = 9
) (
    input  logic                 clock,
    input  logic                 reset_n,
    input  logic                 req_valid,
    input  logic [1:0]           req_op,
    input  logic [ADDR_BITS-1:0] req_addr,
    input  logic [WORD_BITS-1:0] req_wdata,
    input  logic [WORD_BITS-1:0] req_wmask,
    output logic                 req_ready,
    output logic                 resp_done,
    output logic [WORD_BITS-1:0] resp_rdata,
    output logic                 mem_valid,
    output logic [1:0]           mem_op,
    output logic [ADDR_BITS-1:0] mem_addr,
    output logic [LINE_BITS-1:0] mem_wline,
    input  logic                 mem_ready,
    input  logic                 mem_done,
    input  logic [LINE_BITS-1:0] mem_rline
);

    localparam int TAG_W   = tag_bits_f(SET_BITS);
    localparam int ENTRY_W = entry_bits_f(SET_BITS);

    logic                       tag_rd_en;
    logic                       tag_wr_en;
    logic [SET_BITS-1:0]        tag_set;
    logic [WAY_NUM*ENTRY_W-1:0] tag_wr_entry;
    logic [WAY_NUM*ENTRY_W-1:0] tag_rdata;

    logic                       data_wr_en;
    logic [WAY_NUM-1:0]         data_way_en;
    logic [BANK_NUM-1:0]        data_bank_en;
    logic [SET_BITS-1:0]        data_set;
    line_u                      data_wr_line;
    line_u                      data_wr_mask;
    line_u                      data_rdata;

    logic                       lookup_step;
    logic [TAG_W-1:0]           req_tag;
    logic                       hit;
    logic [WAY_SEL_BITS-1:0]    hit_way;
    logic [WAY_SEL_BITS-1:0]    victim_way;
    logic                       victim_dirty;
    logic [TAG_W-1:0]           victim_tag;

    dcache_ctrl #(.SET_BITS(SET_BITS)) u_ctrl (.*);

    dcache_lookup #(.SET_BITS(SET_BITS)) u_lookup (
        .clock        (clock),
        .reset_n      (reset_n),
        .lookup_step  (lookup_step),
        .req_tag      (req_tag),
        .tag_rdata    (tag_rdata),
        .hit          (hit),
        .hit_way      (hit_way),
        .victim_way   (victim_way),
        .victim_dirty (victim_dirty),
        .victim_tag   (victim_tag)
    );

    dcache_tag_array #(.SET_BITS(SET_BITS)) u_tag_array (
        .clock    (clock),
        .reset_n  (reset_n),
        .rd_en    (tag_rd_en),
        .wr_en    (tag_wr_en),
        .set_addr (tag_set),
        .wr_entry (tag_wr_entry),
        .rd_entry (tag_rdata)
    );

    dcache_data_array #(.SET_BITS(SET_BITS)) u_data_array (
        .clock    (clock),
        .wr_en    (data_wr_en),
        .way_en   (data_way_en),
        .bank_en  (data_bank_en),
        .set_addr (data_set),
        .wr_line  (data_wr_line),
        .wr_mask  (data_wr_mask),
        .rd_line  (data_rdata)
    );

endmodule

`default_nettype wire

// File: verif/dcache_props.sv
`timescale 1ns/1ns
`default_nettype none

module dcache_props
    import dcache_pkg::*;
(
    input logic                 clock,
    input logic                 reset_n,
    input logic                 req_valid,
    input logic                 req_ready,
    input logic                 resp_done,
    input logic                 mem_valid,
    input logic                 mem_ready,
    input logic [1:0]           mem_op,
    input logic [ADDR_BITS-1:0] mem_addr,
    input logic [LINE_BITS-1:0] mem_wline
);

    int fail_count = 0;   // read by the testbench at the end

    mem_hold: assert property (@(posedge clock) disable iff (!reset_n)
        mem_valid && !mem_ready |=> mem_valid && $stable(mem_op)
            && $stable(mem_addr) && $stable(mem_wline))
        else begin
            $error("memory request dropped or changed before mem_ready");
            fail_count++;
        end

    done_pulse: assert property (@(posedge clock) disable iff (!reset_n)
        resp_done |=> !resp_done)
        else begin
            $error("resp_done high for two cycles in a row");
            fail_count++;
        end

    // ready stays low from acceptance through the done cycle
    busy_after_accept: assert property (@(posedge clock) disable iff (!reset_n)
        req_valid && req_ready |=> !req_ready)
        else begin
            $error("req_ready high right after acceptance");
            fail_count++;
        end

    busy_until_done: assert property (@(posedge clock) disable iff (!reset_n)
        !req_ready && !resp_done |=> !req_ready)
        else begin
            $error("req_ready rose before resp_done");
            fail_count++;
        end

    reset_state: assert property (@(posedge clock)
        $rose(reset_n) |-> req_ready && !mem_valid && !resp_done)
        else begin
            $error("wrong port state right after reset");
            fail_count++;
        end

endmodule

bind dcache_top dcache_props u_props (
    .clock     (clock),
    .reset_n   (reset_n),
    .req_valid (req_valid),
    .req_ready (req_ready),
    .resp_done (resp_done),
    .mem_valid (mem_valid),
    .mem_ready (mem_ready),
    .mem_op    (mem_op),
    .mem_addr  (mem_addr),
    .mem_wline (mem_wline)
);

`default_nettype wire

// File: verif/dcache_tb.sv
`timescale 1ns/1ns
`default_nettype none

module dcache_tb;

    localparam int         TB_SET_BITS = 4;
    localparam int         NUM_TESTS   = 4;
    localparam logic [1:0] op_read     = 2'b01;
    localparam logic [1:0] op_write    = 2'b10;

    logic         clock;
    logic         reset_n;
    logic         req_valid;
    logic [1:0]   req_op;
    logic [31:0]  req_addr;
    logic [63:0]  req_wdata;
    logic [63:0]  req_wmask;
    logic         req_ready;
    logic         resp_done;
    logic [63:0]  resp_rdata;
    logic         mem_valid;
    logic [1:0]   mem_op;
    logic [31:0]  mem_addr;
    logic [511:0] mem_wline;
    logic         mem_ready;
    logic         mem_done;
    logic [511:0] mem_rline;

    int    seed = 79854;
    int    checks = 0;
    int    errors = 0;
    int    test_checks;
    int    test_errors;
    string test_name;

    logic [63:0]  image [logic [28:0]];       // reference, by word address
    logic [511:0] mem_lines [logic [25:0]];   // lines written back, by line address

    tb_clock #(.PERIOD_NS(100), .RESET_CYCLES(8)) u_clock (
        .clock   (clock),
        .reset_n (reset_n)
    );

    dcache_top #(.SET_BITS(TB_SET_BITS)) u_dut (.*);

    // memory contents before any writeback, a function of the whole address
    function automatic logic [63:0] initial_word(input logic [31:0] addr);
        return {addr[31:3], 3'b101, ~addr[31:3], 3'b010};
    endfunction

    function automatic logic [63:0] expected_word(input logic [31:0] addr);
        if (image.exists(addr[31:3])) begin
            return image[addr[31:3]];
        end
        return initial_word({addr[31:3], 3'b000});
    endfunction

    function automatic logic [511:0] line_from_memory(input logic [25:0] key);
        logic [511:0] line;
        if (mem_lines.exists(key)) begin
            return mem_lines[key];
        end
        for (int b = 0; b < 8; b++) begin
            line[b*64 +: 64] = initial_word({key, 3'(b), 3'b000});
        end
        return line;
    endfunction

    function automatic logic [31:0] make_addr(input int tag, input int set_idx, input int bank);
        return 32'((tag << (6 + TB_SET_BITS)) | (set_idx << 6) | (bank << 3));
    endfunction

    task automatic start_test(input string name);
        test_name   = name;
        test_checks = checks;
        test_errors = errors;
    endtask

    task automatic report_test();
        $display("test %s: %0d checks, %0d errors", test_name,
                 checks - test_checks, errors - test_errors);
    endtask

    task automatic check_word(input string what, input logic [63:0] expected,
                              input logic [63:0] actual);
        checks++;
        assert (actual === expected)
        else begin
            $display("[ERROR] %s: %s expected %h actual %h", test_name, what, expected, actual);
            errors++;
        end
    endtask

    // one request, called on a falling edge, returns on the done edge
    task automatic access(input logic [1:0] op, input logic [31:0] addr,
                          input logic [63:0] wdata, input logic [63:0] wmask,
                          output logic [63:0] rdata);
        while (!req_ready) @(negedge clock);
        req_valid = 1'b1;
        req_op    = op;
        req_addr  = addr;
        req_wdata = wdata;
        req_wmask = wmask;
        @(negedge clock);
        req_valid = 1'b0;
        while (!resp_done) @(negedge clock);
        rdata = resp_rdata;
    endtask

    task automatic write_word(input logic [31:0] addr, input logic [63:0] data,
                              input logic [63:0] mask);
        logic [63:0] old;
        logic [63:0] rdata;
        old = expected_word(addr);
        access(op_write, addr, data, mask, rdata);
        image[addr[31:3]] = (data & mask) | (old & ~mask);
        check_word("write response data", 64'h0, rdata);
    endtask

    task automatic read_check(input logic [31:0] addr, input string what);
        logic [63:0] rdata;
        access(op_read, addr, 64'h0, 64'h0, rdata);
        check_word(what, expected_word(addr), rdata);
    endtask

    initial begin : memory_model
        int          delay;
        logic [25:0] key;
        logic        is_write;
        mem_ready = 1'b0;
        mem_done  = 1'b0;
        mem_rline = '0;
        forever begin
            @(negedge clock);
            if (reset_n && mem_valid) begin
                delay = {$random(seed)} % 4;
                repeat (delay) @(negedge clock);
                mem_ready = 1'b1;
                key       = mem_addr[31:6];
                is_write  = (mem_op == op_write);
                if (is_write) begin
                    mem_lines[key] = mem_wline;
                end
                @(negedge clock);
                mem_ready = 1'b0;
                delay = {$random(seed)} % 4;   // done 1 to 4 cycles after acceptance
                repeat (delay) @(negedge clock);
                mem_done  = 1'b1;
                mem_rline = is_write ? '0 : line_from_memory(key);
                @(negedge clock);
                mem_done  = 1'b0;
            end
        end
    end

    initial begin : watchdog
        repeat (NUM_TESTS * 2000) @(posedge clock);
        $display("watchdog: run did not finish within %0d cycles", NUM_TESTS * 2000);
        $display("Test FAILED");
        $finish;
    end

    initial begin : stimulus
        logic [31:0] a;
        logic [63:0] d;
        logic [63:0] m;
        int          wb_lines;
        int          prop_fails;
        req_valid = 1'b0;
        req_op    = op_read;
        req_addr  = '0;
        req_wdata = '0;
        req_wmask = '0;
        @(posedge reset_n);
        @(negedge clock);

        start_test("read_miss_refill");
        for (int i = 0; i < 4; i++) begin
            read_check(make_addr(i + 1, 8 + i, i), "refilled word");
            read_check(make_addr(i + 1, 8 + i, 7 - i), "word of resident line");
        end
        report_test();

        start_test("masked_write");
        a = make_addr(5, 2, 3);
        d = {$random(seed), $random(seed)};
        write_word(a, d, 64'hff00_0ff0_f0f0_00ff);   // cold line, write miss
        read_check(a, "merged word after write miss");
        read_check(make_addr(5, 2, 4), "neighbour bank after write miss");
        d = {$random(seed), $random(seed)};
        write_word(a, d, 64'h0f0f_0f0f_ffff_0000);   // now a hit
        read_check(a, "merged word after write hit");
        report_test();

        // three lines in a two-way set, so dirty lines get pushed out
        start_test("dirty_eviction");
        for (int t = 0; t < 3; t++) begin
            d = {$random(seed), $random(seed)};
            write_word(make_addr(10 + t, 7, 1), d, '1);
            d = {$random(seed), $random(seed)};
            m = {$random(seed), $random(seed)};
            write_word(make_addr(10 + t, 7, 6), d, m);
        end
        for (int t = 0; t < 3; t++) begin
            read_check(make_addr(10 + t, 7, 1), "full word after eviction");
            read_check(make_addr(10 + t, 7, 6), "masked word after eviction");
        end
        report_test();

        start_test("line_writeback");
        wb_lines = 0;
        foreach (mem_lines[k]) begin
            wb_lines++;
            for (int b = 0; b < 8; b++) begin
                a = {k, 3'(b), 3'b000};
                check_word("written-back word", expected_word(a), mem_lines[k][b*64 +: 64]);
            end
        end
        if (wb_lines == 0) begin
            $display("line_writeback: no dirty line was ever written back to memory");
            errors++;
        end
        report_test();

        prop_fails = u_dut.u_props.fail_count;
        $display("summary: %0d tests, %0d checks, %0d check errors, %0d property failures",
                 NUM_TESTS, checks, errors, prop_fails);
        if (errors == 0 && prop_fails == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: verif/tb_clock.sv
`timescale 1ns/1ns
`default_nettype none

module tb_clock #(
    parameter int PERIOD_NS    = 100,
    parameter int RESET_CYCLES = 8
) (
    output logic clock,
    output logic reset_n
);

    initial begin
        clock = 1'b0;
        forever #(PERIOD_NS / 2) clock = ~clock;
    end

    // release on a falling edge, away from the sampling edge
    initial begin
        reset_n = 1'b0;
        repeat (RESET_CYCLES) @(posedge clock);
        @(negedge clock);
        reset_n = 1'b1;
    end

endmodule

`default_nettype wire
